/* ofdm_tx_pkg.sv */
// Legacy 802.11a rates only; the header length counts the 4-byte FCS and must be at least 5
package ofdm_tx_pkg;

    // Rate code as found in header bits 3 to 0
    typedef logic [3:0] rate_code_t;

    localparam rate_code_t RATE_6M  = 4'b1011;
    localparam rate_code_t RATE_9M  = 4'b1111;
    localparam rate_code_t RATE_12M = 4'b1010;
    localparam rate_code_t RATE_18M = 4'b1110;
    localparam rate_code_t RATE_24M = 4'b1001;
    localparam rate_code_t RATE_36M = 4'b1101;
    localparam rate_code_t RATE_48M = 4'b1000;
    localparam rate_code_t RATE_54M = 4'b1100;

    // Transmit fields in the order they go out
    typedef enum logic [2:0] {
        FIELD_IDLE,
        FIELD_SIGNAL,
        FIELD_SERVICE,
        FIELD_PSDU,
        FIELD_FCS,
        FIELD_TAIL,
        FIELD_PAD
    } field_t;

    localparam int DBPS_W       = 9;
    localparam int LEN_W        = 12;
    localparam int SIGNAL_BITS  = 24;
    localparam int SERVICE_BITS = 16;
    localparam int TAIL_BITS    = 6;
    localparam int FCS_BITS     = 32;
    localparam int WORD_W       = 64;

    // Rate-1/2 mother code, bit 6 taps the current input
    localparam logic [6:0] CONV_G0 = 7'o133;
    localparam logic [6:0] CONV_G1 = 7'o171;

    // Reflected CRC-32 for the FCS
    localparam logic [31:0] CRC32_POLY = 32'hEDB8_8320;
    localparam logic [31:0] CRC32_INIT = 32'hFFFF_FFFF;

    function automatic logic [DBPS_W-1:0] dbps_of_rate(input rate_code_t rate);
        case (rate)
            RATE_9M:  return DBPS_W'(36);
            RATE_12M: return DBPS_W'(48);
            RATE_18M: return DBPS_W'(72);
            RATE_24M: return DBPS_W'(96);
            RATE_36M: return DBPS_W'(144);
            RATE_48M: return DBPS_W'(192);
            RATE_54M: return DBPS_W'(216);
            default:  return DBPS_W'(24);
        endcase
    endfunction

endpackage

/* tx_field_fsm.sv */
// Start is taken only when idle and the previous packet's last pair has left the encoder
module tx_field_fsm import ofdm_tx_pkg::*; (
    input  logic   clk,
    input  logic   reset_int,
    input  logic   i_tx_start,
    input  logic   i_last_bit,
    input  logic   i_advance,
    output field_t o_field,
    output logic   o_header_load,
    output logic   o_enc_clear,
    output logic   o_scram_load,
    output logic   o_tx_busy,
    output logic   o_tx_done
);

    field_t field_q;
    logic   drain_q;
    logic   header_load_q;
    logic   tx_done_q;

    ////////////////////////////////////////////////////////////////////////////
    // Field sequencing
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (reset_int) begin
            field_q       <= FIELD_IDLE;
            drain_q       <= 1'b0;
            header_load_q <= 1'b0;
            tx_done_q     <= 1'b0;
        end else begin
            header_load_q <= 1'b0;
            tx_done_q     <= 1'b0;
            if (i_advance) begin
                // Advance while draining means the final pair is being taken
                if (drain_q) begin
                    drain_q   <= 1'b0;
                    tx_done_q <= 1'b1;
                end
                case (field_q)
                    FIELD_IDLE: begin
                        if (i_tx_start && !drain_q) begin
                            field_q       <= FIELD_SIGNAL;
                            header_load_q <= 1'b1;
                        end
                    end
                    FIELD_SIGNAL:  if (i_last_bit) field_q <= FIELD_SERVICE;
                    FIELD_SERVICE: if (i_last_bit) field_q <= FIELD_PSDU;
                    FIELD_PSDU:    if (i_last_bit) field_q <= FIELD_FCS;
                    FIELD_FCS:     if (i_last_bit) field_q <= FIELD_TAIL;
                    FIELD_TAIL:    if (i_last_bit) field_q <= FIELD_PAD;
                    FIELD_PAD: begin
                        if (i_last_bit) begin
                            field_q <= FIELD_IDLE;
                            drain_q <= 1'b1;
                        end
                    end
                    default: field_q <= FIELD_IDLE;
                endcase
            end
        end
    end

    assign o_field       = field_q;
    assign o_header_load = header_load_q;
    assign o_tx_done     = tx_done_q;
    assign o_tx_busy     = (field_q != FIELD_IDLE) || drain_q;

    // Encoder history is zero for SIGNAL and again for SERVICE
    assign o_enc_clear  = (field_q == FIELD_IDLE) || (field_q == FIELD_SIGNAL && i_last_bit);

    // Seed goes in as the last SIGNAL bit is taken
    assign o_scram_load = i_advance && field_q == FIELD_SIGNAL && i_last_bit;

endmodule

/* tx_bit_counter.sv */
// PAD is never empty for legacy rates since 22 + 8*len is 6 mod 8 and no N_DBPS divides it
module tx_bit_counter import ofdm_tx_pkg::*; (
    input  logic              clk,
    input  logic              reset_int,
    input  field_t            i_field,
    input  logic              i_advance,
    input  logic              i_header_load,
    input  logic [WORD_W-1:0] i_header,
    output logic              o_last_bit
);

    localparam int CNT_W = LEN_W + 3;

    logic [LEN_W-1:0]  len_q;
    logic [DBPS_W-1:0] dbps_q;
    logic [CNT_W-1:0]  bit_cnt;
    logic [DBPS_W-1:0] sym_cnt;
    logic [CNT_W-1:0]  field_len;
    logic              sym_end;
    logic              in_data;

    // Header word: rate code in bits 3..0, byte length from bit 5
    always_ff @(posedge clk) begin
        if (i_header_load) begin
            len_q  <= i_header[5 +: LEN_W];
            dbps_q <= dbps_of_rate(rate_code_t'(i_header[3:0]));
        end
    end

    always_comb begin
        case (i_field)
            FIELD_SIGNAL:  field_len = CNT_W'(SIGNAL_BITS);
            FIELD_SERVICE: field_len = CNT_W'(SERVICE_BITS);
            FIELD_PSDU:    field_len = {len_q, 3'b000} - CNT_W'(FCS_BITS);
            FIELD_FCS:     field_len = CNT_W'(FCS_BITS);
            FIELD_TAIL:    field_len = CNT_W'(TAIL_BITS);
            default:       field_len = '0;
        endcase
    end

    assign sym_end = (sym_cnt == dbps_q - 1'b1);
    assign in_data = (i_field != FIELD_IDLE) && (i_field != FIELD_SIGNAL);

    always_comb begin
        if (i_field == FIELD_IDLE)
            o_last_bit = 1'b0;
        else if (i_field == FIELD_PAD)
            o_last_bit = sym_end;
        else
            o_last_bit = (bit_cnt == field_len - 1'b1);
    end

    // Symbol position starts with the first SERVICE bit
    always_ff @(posedge clk) begin
        if (reset_int) begin
            bit_cnt <= '0;
            sym_cnt <= '0;
        end else if (i_advance) begin
            if (i_field == FIELD_IDLE || o_last_bit)
                bit_cnt <= '0;
            else
                bit_cnt <= bit_cnt + 1'b1;
            if (!in_data || sym_end)
                sym_cnt <= '0;
            else
                sym_cnt <= sym_cnt + 1'b1;
        end
    end

endmodule

/* tx_bit_source.sv */
// Memory must return the word one cycle after the address; address 0 is shown while idle
module tx_bit_source import ofdm_tx_pkg::*; #(
    parameter int MEM_ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  reset_int,
    input  logic                  i_tx_start,
    input  field_t                i_field,
    input  logic                  i_advance,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    input  logic [WORD_W-1:0]     i_mem_data,
    output logic [WORD_W-1:0]     o_header,
    output logic                  o_raw_bit
);

    localparam int PTR_W = $clog2(WORD_W);

    logic [WORD_W-1:0]     cur_word;
    logic [WORD_W-1:0]     nxt_word;
    logic [PTR_W-1:0]      bit_ptr;
    logic [MEM_ADDR_W-1:0] word_addr;
    logic                  word_end;

    // SIGNAL ends after 24 header bits, PSDU words after all 64
    assign word_end = (i_field == FIELD_SIGNAL && bit_ptr == PTR_W'(SIGNAL_BITS - 1)) ||
                      (i_field == FIELD_PSDU && bit_ptr == PTR_W'(WORD_W - 1));

    assign o_mem_addr = (i_field == FIELD_IDLE) ? '0 : word_addr;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            bit_ptr   <= '0;
            word_addr <= '0;
        end else if (i_advance) begin
            if (i_field == FIELD_IDLE) begin
                if (i_tx_start) begin
                    bit_ptr   <= '0;
                    word_addr <= MEM_ADDR_W'(1);
                end
            end else if (word_end) begin
                bit_ptr   <= '0;
                word_addr <= word_addr + 1'b1;
            end else if (i_field == FIELD_SIGNAL || i_field == FIELD_PSDU) begin
                bit_ptr <= bit_ptr + 1'b1;
            end
        end
    end

    // Prefetch follows the address freely, it moves only on advance
    always_ff @(posedge clk) begin
        nxt_word <= i_mem_data;
        if (i_advance) begin
            if (i_field == FIELD_IDLE && i_tx_start)
                cur_word <= i_mem_data;
            else if (word_end)
                cur_word <= nxt_word;
        end
    end

    assign o_header  = cur_word;
    assign o_raw_bit = cur_word[bit_ptr];

endmodule

/* crc32_fcs.sv */
// Shift-out complements on the fly, so the remainder is only valid after all PSDU bits
module crc32_fcs import ofdm_tx_pkg::*; (
    input  logic clk,
    input  logic reset_int,
    input  logic i_init,
    input  logic i_shift_data,
    input  logic i_shift_out,
    input  logic i_data_bit,
    output logic o_fcs_bit
);

    logic [FCS_BITS-1:0] crc;
    logic                feedback;

    assign feedback = crc[0] ^ i_data_bit;

    always_ff @(posedge clk) begin
        if (reset_int || i_init) begin
            crc <= CRC32_INIT;
        end else if (i_shift_data) begin
            crc <= (crc >> 1) ^ (feedback ? CRC32_POLY : '0);
        end else if (i_shift_out) begin
            crc <= crc >> 1;
        end
    end

    // FCS goes out inverted, LSB first
    assign o_fcs_bit = ~crc[0];

endmodule

/* data_scrambler.sv */
// Seed must be nonzero; load wins over step
module data_scrambler (
    input  logic       clk,
    input  logic       reset_int,
    input  logic       i_load,
    input  logic [6:0] i_init_state,
    input  logic       i_step,
    output logic       o_white_bit
);

    logic [6:0] state;

    // x^7 + x^4 + 1
    assign o_white_bit = state[6] ^ state[3];

    always_ff @(posedge clk) begin
        if (reset_int) begin
            state <= '0;
        end else if (i_load) begin
            state <= i_init_state;
        end else if (i_step) begin
            state <= {state[5:0], o_white_bit};
        end
    end

endmodule

/* conv_encoder.sv */
// Output bit 0 carries the g0 (133) parity, bit 1 the g1 (171) parity
module conv_encoder import ofdm_tx_pkg::*; (
    input  logic       clk,
    input  logic       reset_int,
    input  logic       i_clear,
    input  logic       i_bit,
    input  logic       i_bit_valid,
    output logic       o_advance,
    output logic [1:0] o_coded_bits,
    output logic       o_coded_valid,
    input  logic       i_coded_ready
);

    logic [5:0] hist;
    logic [6:0] window;
    logic [1:0] pair_q;
    logic       valid_q;

    // hist[5] is the previous bit, hist[0] the oldest
    assign window    = {i_bit, hist};
    assign o_advance = !valid_q || i_coded_ready;

    always_ff @(posedge clk) begin
        if (reset_int) begin
            hist    <= '0;
            valid_q <= 1'b0;
        end else if (o_advance) begin
            valid_q <= i_bit_valid;
            if (i_clear)
                hist <= '0;
            else if (i_bit_valid)
                hist <= {i_bit, hist[5:1]};
        end
    end

    // Clear applies after the current bit is coded
    always_ff @(posedge clk) begin
        if (o_advance && i_bit_valid)
            pair_q <= {^(window & CONV_G1), ^(window & CONV_G0)};
    end

    assign o_coded_bits  = pair_q;
    assign o_coded_valid = valid_q;

endmodule

/* ofdm_tx_bits_top.sv */
// Bit front end only; the consumer applies puncturing, interleaving and mapping
module ofdm_tx_bits_top import ofdm_tx_pkg::*; #(
    parameter int MEM_ADDR_W = 12
) (
    input  logic                  clk,
    input  logic                  reset_int,
    input  logic                  i_tx_start,
    input  logic [6:0]            i_scram_init,
    output logic [MEM_ADDR_W-1:0] o_mem_addr,
    input  logic [WORD_W-1:0]     i_mem_data,
    output logic [1:0]            o_coded_bits,
    output logic                  o_coded_valid,
    input  logic                  i_coded_ready,
    output logic                  o_tx_busy,
    output logic                  o_tx_done
);

    field_t            field;
    logic              advance;
    logic              header_load;
    logic              enc_clear;
    logic              scram_load;
    logic              last_bit;
    logic [WORD_W-1:0] header;
    logic              raw_bit;
    logic              fcs_bit;
    logic              white_bit;
    logic              scram_step;
    logic              enc_bit;

    ////////////////////////////////////////////////////////////////////////////
    // Bit selection and whitening
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        case (field)
            FIELD_SIGNAL:  enc_bit = raw_bit;
            FIELD_SERVICE: enc_bit = white_bit;
            FIELD_PSDU:    enc_bit = raw_bit ^ white_bit;
            FIELD_FCS:     enc_bit = fcs_bit ^ white_bit;
            FIELD_PAD:     enc_bit = white_bit;
            default:       enc_bit = 1'b0;
        endcase
    end

    // Scrambler holds through the tail
    assign scram_step = advance && (field inside {FIELD_SERVICE, FIELD_PSDU, FIELD_FCS, FIELD_PAD});

    tx_field_fsm u_fsm (
        .clk(clk), .reset_int(reset_int), .i_tx_start(i_tx_start), .i_last_bit(last_bit),
        .i_advance(advance), .o_field(field), .o_header_load(header_load),
        .o_enc_clear(enc_clear), .o_scram_load(scram_load), .o_tx_busy(o_tx_busy),
        .o_tx_done(o_tx_done)
    );

    tx_bit_counter u_counter (
        .clk(clk), .reset_int(reset_int), .i_field(field), .i_advance(advance),
        .i_header_load(header_load), .i_header(header), .o_last_bit(last_bit)
    );

    tx_bit_source #(.MEM_ADDR_W(MEM_ADDR_W)) u_source (
        .clk(clk), .reset_int(reset_int), .i_tx_start(i_tx_start), .i_field(field),
        .i_advance(advance), .o_mem_addr(o_mem_addr), .i_mem_data(i_mem_data),
        .o_header(header), .o_raw_bit(raw_bit)
    );

    crc32_fcs u_crc (
        .clk(clk), .reset_int(reset_int), .i_init(header_load),
        .i_shift_data(advance && field == FIELD_PSDU),
        .i_shift_out(advance && field == FIELD_FCS), .i_data_bit(raw_bit),
        .o_fcs_bit(fcs_bit)
    );

    data_scrambler u_scrambler (
        .clk(clk), .reset_int(reset_int), .i_load(scram_load), .i_init_state(i_scram_init),
        .i_step(scram_step), .o_white_bit(white_bit)
    );

    conv_encoder u_encoder (
        .clk(clk), .reset_int(reset_int), .i_clear(enc_clear), .i_bit(enc_bit),
        .i_bit_valid(field != FIELD_IDLE), .o_advance(advance), .o_coded_bits(o_coded_bits),
        .o_coded_valid(o_coded_valid), .i_coded_ready(i_coded_ready)
    );

endmodule

/* tb_clock_gen.sv */
// Free-running clock of period 100; reset is released after 8 rising edges
module tb_clock_gen (
    output logic clk,
    output logic reset_int
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        reset_int = 1'b1;
        repeat (8) @(posedge clk);
        reset_int <= 1'b0;
    end

endmodule

/* tb_ofdm_tx_bits.sv */
// Memory answers with one-cycle latency; back-to-back packets reuse the same memory contents
module tb_ofdm_tx_bits;

    localparam int MEM_ADDR_W = 12;
    localparam int NUM_PKTS   = 13;

    logic                  clk;
    logic                  reset_int;
    logic                  i_tx_start;
    logic [6:0]            i_scram_init;
    logic [MEM_ADDR_W-1:0] mem_addr;
    logic [63:0]           mem_data;
    logic [1:0]            o_coded_bits;
    logic                  o_coded_valid;
    logic                  i_coded_ready;
    logic                  o_tx_busy;
    logic                  o_tx_done;

    logic [63:0] mem [0:(1 << MEM_ADDR_W) - 1];
    logic [1:0]  exp_q [$];
    logic [6:0]  enc_state;
    logic [3:0]  pkt_rate [NUM_PKTS];
    int          pkt_len [NUM_PKTS];
    int          seed;
    int          err_cnt;
    int          pairs_checked;
    int          pair_idx;
    int          done_cnt;
    int          cycle_cnt;
    int          timeout_limit;
    logic        random_ready;
    logic        hold_pending;
    logic [1:0]  held_bits;
    logic        done_prev;
    string       test_name;

    tb_clock_gen clock_i (.clk(clk), .reset_int(reset_int));

    ofdm_tx_bits_top #(.MEM_ADDR_W(MEM_ADDR_W)) dut_i (
        .clk(clk), .reset_int(reset_int), .i_tx_start(i_tx_start),
        .i_scram_init(i_scram_init), .o_mem_addr(mem_addr), .i_mem_data(mem_data),
        .o_coded_bits(o_coded_bits), .o_coded_valid(o_coded_valid),
        .i_coded_ready(i_coded_ready), .o_tx_busy(o_tx_busy), .o_tx_done(o_tx_done)
    );

    // Memory model with one cycle of read latency
    always @(posedge clk) mem_data <= mem[mem_addr];

    always @(posedge clk) begin
        i_coded_ready <= random_ready ? (($random(seed) & 3) != 0) : 1'b1;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////////////////////
    function automatic int dbps_for(input logic [3:0] rate);
        case (rate)
            4'b1111: return 36;
            4'b1010: return 48;
            4'b1110: return 72;
            4'b1001: return 96;
            4'b1101: return 144;
            4'b1000: return 192;
            4'b1100: return 216;
            default: return 24;
        endcase
    endfunction

    // Rate codes from 6 to 54 Mbps
    function automatic logic [3:0] rate_by_speed(input int i);
        case (i)
            0: return 4'b1011;
            1: return 4'b1111;
            2: return 4'b1010;
            3: return 4'b1110;
            4: return 4'b1001;
            5: return 4'b1101;
            6: return 4'b1000;
            default: return 4'b1100;
        endcase
    endfunction

    function automatic int pair_count(input int len, input logic [3:0] rate);
        int dbps;
        dbps = dbps_for(rate);
        return 24 + ((22 + 8 * len + dbps - 1) / dbps) * dbps;
    endfunction

    function automatic void push_coded(input logic b);
        logic g0;
        logic g1;
        enc_state = {enc_state[5:0], b};
        // 133 taps delays 0, 2, 3, 5, 6 and 171 taps delays 0, 1, 2, 3, 6
        g0 = enc_state[0] ^ enc_state[2] ^ enc_state[3] ^ enc_state[5] ^ enc_state[6];
        g1 = enc_state[0] ^ enc_state[1] ^ enc_state[2] ^ enc_state[3] ^ enc_state[6];
        exp_q.push_back({g1, g0});
    endfunction

    function automatic int build_expected(input logic [6:0] scr_seed);
        logic [63:0] hdr;
        logic [31:0] crc;
        logic [6:0]  scr;
        logic        d;
        logic        w;
        int          len;
        int          plen;
        int          dbps;
        int          ndata;
        int          k;
        int          p;
        hdr   = mem[0];
        len   = int'(hdr[16:5]);
        dbps  = dbps_for(hdr[3:0]);
        plen  = 8 * len - 32;
        ndata = ((22 + 8 * len + dbps - 1) / dbps) * dbps;
        enc_state = '0;
        for (k = 0; k < 24; k++) begin
            push_coded(hdr[k]);
        end
        // DATA starts again from a cleared encoder
        enc_state = '0;
        crc = 32'hffff_ffff;
        scr = scr_seed;
        for (k = 0; k < ndata; k++) begin
            p = k - 16;
            if (k < 16) begin
                d = 1'b0;
            end else if (p < plen) begin
                d   = mem[1 + p / 64][p % 64];
                crc = (crc >> 1) ^ ((crc[0] ^ d) ? 32'hedb8_8320 : 32'h0);
            end else if (p < plen + 32) begin
                d = ~crc[p - plen];
            end else begin
                d = 1'b0;
            end
            // Tail goes out as plain zeros while the scrambler waits
            if (k >= 16 && p >= plen + 32 && p < plen + 38) begin
                push_coded(d);
            end else begin
                w   = scr[6] ^ scr[3];
                scr = {scr[5:0], w};
                push_coded(d ^ w);
            end
        end
        return 24 + ndata;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checkers
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk) begin : compare_pairs
        logic [1:0] exp_pair;
        if (!reset_int && o_coded_valid && i_coded_ready) begin
            assert (exp_q.size() > 0) else begin
                err_cnt++;
                $display("Test %s sent an extra coded pair %b", test_name, o_coded_bits);
            end
            if (exp_q.size() > 0) begin
                exp_pair = exp_q.pop_front();
                assert (o_coded_bits == exp_pair) else begin
                    err_cnt++;
                    $display("ERROR %s pair %0d (%s): expected %b actual %b", test_name,
                             pair_idx, (pair_idx < 24) ? "signal" : "data", exp_pair,
                             o_coded_bits);
                end
                pair_idx++;
                pairs_checked++;
            end
        end
    end

    // Valid and data must hold while the consumer stalls
    always @(posedge clk) begin
        if (!reset_int && hold_pending) begin
            assert (o_coded_valid && o_coded_bits == held_bits) else begin
                err_cnt++;
                $display("Test %s: coded pair dropped or changed before it was taken", test_name);
            end
        end
        hold_pending <= !reset_int && o_coded_valid && !i_coded_ready;
        held_bits    <= o_coded_bits;
    end

    always @(posedge clk) begin
        if (!reset_int && o_tx_done) begin
            done_cnt++;
            assert (exp_q.size() == 0) else begin
                err_cnt++;
                $display("Test %s: done came with %0d pairs missing", test_name, exp_q.size());
            end
            assert (!done_prev) else begin
                err_cnt++;
                $display("Test %s: done stayed high for more than one cycle", test_name);
            end
        end
        done_prev <= o_tx_done;
    end

    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_cnt > timeout_limit) begin
            $display("Run stopped after %0d cycles without finishing test %s", cycle_cnt,
                     test_name);
            $display("Summary: %0d errors, %0d pairs checked, %0d done pulses", err_cnt,
                     pairs_checked, done_cnt);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    task automatic load_packet(input int idx);
        logic [11:0] len;
        logic [3:0]  rate;
        int          nwords;
        int          w;
        @(negedge clk);
        len    = 12'(pkt_len[idx]);
        rate   = pkt_rate[idx];
        mem[0] = {$random(seed), 8'h00, 6'b0, ^{len, rate}, len, 1'b0, rate};
        nwords = (8 * pkt_len[idx] - 32 + 63) / 64;
        for (w = 1; w <= nwords; w++) begin
            mem[w] = {$random(seed), $random(seed)};
        end
        @(posedge clk);
        @(posedge clk);
    endtask

    task automatic send_packet(input string name, input logic [6:0] scr_seed, input logic rnd);
        int n;
        @(posedge clk);
        test_name    = name;
        pair_idx     = 0;
        random_ready <= rnd;
        n = build_expected(scr_seed);
        i_scram_init <= scr_seed;
        i_tx_start   <= 1'b1;
        @(posedge clk);
        while (!o_tx_busy) @(posedge clk);
        i_tx_start <= 1'b0;
        while (!o_tx_done) @(posedge clk);
        assert (pair_idx == n) else begin
            err_cnt++;
            $display("ERROR %s pair count: expected %0d actual %0d", name, n, pair_idx);
        end
    endtask

    initial begin
        int a;
        int i;
        int total;
        seed          = 32'hfe1a;
        i_tx_start    = 1'b0;
        i_scram_init  = 7'h5d;
        i_coded_ready = 1'b1;
        mem_data      = '0;
        random_ready  = 1'b0;
        hold_pending  = 1'b0;
        done_prev     = 1'b0;
        err_cnt       = 0;
        pairs_checked = 0;
        pair_idx      = 0;
        done_cnt      = 0;
        cycle_cnt     = 0;
        test_name     = "reset";
        for (a = 0; a < (1 << MEM_ADDR_W); a++) begin
            mem[a] = {~32'(a), 32'(a) ^ 32'h0bad_f00d};
        end
        pkt_rate[0] = 4'b1011;
        pkt_len[0]  = 10;
        pkt_rate[1] = 4'b1010;
        pkt_len[1]  = 40;
        for (i = 0; i < 8; i++) begin
            pkt_rate[2 + i] = rate_by_speed(i);
            pkt_len[2 + i]  = 5 + 9 * i;
        end
        pkt_rate[10] = 4'b1100;
        pkt_len[10]  = 100;
        pkt_rate[11] = 4'b1001;
        pkt_len[11]  = 30;
        pkt_rate[12] = 4'b1001;
        pkt_len[12]  = 30;
        total = 0;
        for (i = 0; i < NUM_PKTS; i++) begin
            total += pair_count(pkt_len[i], pkt_rate[i]);
        end
        timeout_limit = 4 * total + 200;

        while (reset_int) @(posedge clk);
        assert (!o_coded_valid && !o_tx_busy && !o_tx_done) else begin
            err_cnt++;
            $display("Outputs were not idle after reset");
        end

        load_packet(0);
        send_packet("signal_6m", 7'h5d, 1'b0);
        load_packet(1);
        send_packet("payload_words", 7'h3b, 1'b0);
        for (i = 0; i < 8; i++) begin
            load_packet(2 + i);
            send_packet($sformatf("rate_sweep_%0d", i), 7'(7 + 11 * i), 1'b0);
        end
        load_packet(10);
        send_packet("ready_gaps", 7'h6a, 1'b1);
        // Second start follows the first done directly
        load_packet(11);
        send_packet("back_to_back_a", 7'h5d, 1'b1);
        send_packet("back_to_back_b", 7'h21, 1'b1);

        repeat (4) @(posedge clk);
        assert (done_cnt == NUM_PKTS && exp_q.size() == 0) else begin
            err_cnt++;
            $display("Saw %0d done pulses for %0d packets", done_cnt, NUM_PKTS);
        end
        $display("Summary: %0d errors, %0d pairs checked, %0d done pulses", err_cnt,
                 pairs_checked, done_cnt);
        if (err_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

/* ofdm_tx_bits.f */
ofdm_tx_pkg.sv
tx_field_fsm.sv
tx_bit_counter.sv
tx_bit_source.sv
crc32_fcs.sv
data_scrambler.sv
conv_encoder.sv
ofdm_tx_bits_top.sv
tb_clock_gen.sv
tb_ofdm_tx_bits.sv

/* Bender.yml */
package:
  name: ofdm_tx_bits

sources:
  - files:
      - ofdm_tx_pkg.sv
      - tx_field_fsm.sv
      - tx_bit_counter.sv
      - tx_bit_source.sv
      - crc32_fcs.sv
      - data_scrambler.sv
      - conv_encoder.sv
      - ofdm_tx_bits_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_ofdm_tx_bits.sv
